// ==== build.f ====
+incdir+testbench
rtl/usb_proto_pkg.sv
rtl/sie_pkg.sv
rtl/token_decoder.sv
rtl/data_rx_path.sv
rtl/sie_ctrl.sv
rtl/sie_top.sv
testbench/tb_sie.sv

// ==== rtl/data_rx_path.sv ====
// ************************************************************
// OUT data receive path.
// Two-byte delay line that strips the CRC16 bytes,
// and the running CRC16 residual check.
// ************************************************************
`default_nettype none

module data_rx_path
   import usb_proto_pkg::*;
   import sie_pkg::*;
(
   input  wire        clk_i,
   input  wire        rstn,
   input  wire byte_t rx_data_i,
   input  wire        data_start,
   input  wire        data_byte_en,
   input  wire        data_end,
   output byte_t      out_data_o,
   output logic       out_valid_o,
   output logic       crc_ok
);

   byte_t       dly0_q;
   byte_t       dly1_q;
   logic [1:0]  fill_q;
   logic [15:0] crc_q;
   logic [15:0] crc_next;

   assign crc_next = crc16_step(rx_data_i, crc_q);
   // Valid with the last byte only.
   assign crc_ok   = (crc_next == CRC16_RESIDUAL);

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         fill_q      <= 2'd0;
         out_valid_o <= 1'b0;
      end else begin
         out_valid_o <= data_byte_en && (fill_q == 2'd2);
         if (data_start || data_end)
            fill_q <= 2'd0;
         else if (data_byte_en && fill_q != 2'd2)
            fill_q <= fill_q + 2'd1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (data_start)
         crc_q <= '1;
      else if (data_byte_en)
         crc_q <= crc_next;
      if (data_byte_en) begin
         dly0_q     <= rx_data_i;
         dly1_q     <= dly0_q;
         out_data_o <= dly1_q;
      end
   end

   a_no_valid_after_start: assert property (@(posedge clk_i) disable iff (!rstn)
      data_start |=> !out_valid_o);

endmodule

`default_nettype wire

// ==== rtl/sie_ctrl.sv ====
// ************************************************************
// Packet sequencing FSM of the device engine.
// PID check, token and data stage control,
// OUT toggle tracking and handshake transmit.
// ************************************************************
`default_nettype none

module sie_ctrl
   import usb_proto_pkg::*;
   import sie_pkg::*;
#(
   parameter endp_t ENDP_CTRL = 4'd0,
   parameter endp_t ENDP_BULK = 4'd1
) (
   input  wire        clk_i,
   input  wire        rstn,
   input  wire byte_t rx_data_i,
   input  wire        rx_strobe_i,
   input  wire        rx_active_i,
   input  wire        rx_err_i,
   input  wire        tx_done_i,
   input  wire        stall_i,
   input  wire        out_nak_i,
   input  wire        out_toggle_reset_i,
   input  wire        tok_ok,
   input  wire        addr_match,
   input  wire endp_t tok_endp,
   input  wire        crc_ok,
   output logic       tok_byte_en,
   output logic       tok_end,
   output logic       tok_is_sof,
   output logic       data_start,
   output logic       data_byte_en,
   output logic       data_end,
   output logic       tx_valid_o,
   output byte_t      tx_data_o,
   output logic       out_eop_o,
   output logic       out_err_o,
   output logic       setup_o
);

   ctrl_state_t state_q, state_d;
   pid_t        pid_q, pid_d;
   pid_t        rx_pid;
   pid_t        hs_pid;
   logic        pid_valid;
   logic        is_data_pid;
   logic        tok_second_q, tok_second_d;
   logic        tog_ctrl_q, tog_ctrl_d;
   logic        tog_bulk_q, tog_bulk_d;
   logic        tog_cur;
   logic        endp_known;
   logic        eop_d;
   logic        err_d;
   logic        tx_start;

   // PID byte carries its own complement in the upper nibble.
   assign rx_pid      = pid_t'(rx_data_i[3:0]);
   assign pid_valid   = (rx_data_i[7:4] == ~rx_data_i[3:0]);
   assign is_data_pid = (rx_pid == PID_DATA0) || (rx_pid == PID_DATA1);

   assign tok_is_sof = (pid_q == PID_SOF);
   assign setup_o    = (pid_q == PID_SETUP);

   assign endp_known = (tok_endp == ENDP_CTRL) || (tok_endp == ENDP_BULK);
   assign tog_cur    = (tok_endp == ENDP_CTRL) ? tog_ctrl_q : tog_bulk_q;

   // Stall wins over NAK.
   assign hs_pid = stall_i ? PID_STALL : (out_nak_i ? PID_NAK : PID_ACK);

   always_comb begin
      state_d      = state_q;
      pid_d        = pid_q;
      tok_second_d = tok_second_q;
      tog_ctrl_d   = tog_ctrl_q;
      tog_bulk_d   = tog_bulk_q;
      tok_byte_en  = 1'b0;
      tok_end      = 1'b0;
      data_start   = 1'b0;
      data_byte_en = 1'b0;
      data_end     = 1'b0;
      eop_d        = 1'b0;
      err_d        = 1'b0;
      tx_start     = 1'b0;

      if (out_toggle_reset_i) begin
         tog_bulk_d = 1'b0;
      end

      if (rx_err_i && state_q != TX_HANDSHAKE) begin
         state_d = IDLE;
         err_d   = (state_q == RX_DATA);
      end else begin
         case (state_q)
            // IDLE expects a token, RX_PID expects the data packet after one.
            IDLE, RX_PID: begin
               if (tok_ok && addr_match && (pid_q == PID_OUT || pid_q == PID_SETUP)) begin
                  state_d = RX_PID;
                  if (pid_q == PID_SETUP) begin
                     tog_ctrl_d = 1'b0;
                  end
               end
               if (rx_strobe_i) begin
                  pid_d   = pid_valid ? rx_pid : PID_RESERVED;
                  state_d = rx_active_i ? RX_WAIT_EOP : IDLE;
                  if (pid_valid && rx_pid[1:0] == 2'b01 && rx_active_i) begin
                     state_d      = RX_TOKEN;
                     tok_second_d = 1'b0;
                  end else if (pid_valid && is_data_pid && rx_active_i && state_q == RX_PID) begin
                     state_d    = RX_DATA;
                     data_start = 1'b1;
                  end
               end
            end
            RX_TOKEN: begin
               if (rx_strobe_i) begin
                  tok_byte_en  = 1'b1;
                  tok_second_d = 1'b1;
                  if (!tok_second_q) begin
                     if (!rx_active_i) begin
                        state_d = IDLE;
                     end
                  end else if (rx_active_i) begin
                     // Token longer than three bytes.
                     state_d = RX_WAIT_EOP;
                  end else begin
                     tok_end = 1'b1;
                     state_d = IDLE;
                  end
               end
            end
            RX_DATA: begin
               if (rx_strobe_i) begin
                  data_byte_en = 1'b1;
                  if (!rx_active_i) begin
                     data_end = 1'b1;
                     state_d  = IDLE;
                     if (!crc_ok) begin
                        err_d = 1'b1;
                     end else begin
                        state_d  = TX_HANDSHAKE;
                        tx_start = 1'b1;
                        if (endp_known && tog_cur == pid_q[3]) begin
                           eop_d = 1'b1;
                           // A NAK leaves the toggle, so the packet is retried.
                           if (stall_i || !out_nak_i) begin
                              if (tok_endp == ENDP_CTRL)
                                 tog_ctrl_d = ~tog_ctrl_q;
                              else
                                 tog_bulk_d = ~tog_bulk_q;
                           end
                        end else begin
                           err_d = 1'b1;
                        end
                     end
                  end
               end
            end
            RX_WAIT_EOP: begin
               if (rx_strobe_i && !rx_active_i) begin
                  state_d = IDLE;
               end
            end
            TX_HANDSHAKE: begin
               if (tx_done_i) begin
                  state_d = IDLE;
               end
            end
            default: begin
               state_d = IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         state_q      <= IDLE;
         pid_q        <= PID_RESERVED;
         tok_second_q <= 1'b0;
         tog_ctrl_q   <= 1'b0;
         tog_bulk_q   <= 1'b0;
         out_eop_o    <= 1'b0;
         out_err_o    <= 1'b0;
         tx_valid_o   <= 1'b0;
      end else begin
         state_q      <= state_d;
         pid_q        <= pid_d;
         tok_second_q <= tok_second_d;
         tog_ctrl_q   <= tog_ctrl_d;
         tog_bulk_q   <= tog_bulk_d;
         out_eop_o    <= eop_d;
         out_err_o    <= err_d;
         if (tx_start)
            tx_valid_o <= 1'b1;
         else if (tx_done_i)
            tx_valid_o <= 1'b0;
      end
   end

   // Handshake byte, held until the transmitter takes it.
   always_ff @(posedge clk_i) begin
      if (tx_start) begin
         tx_data_o <= {~hs_pid, hs_pid};
      end
   end

   a_tx_in_handshake: assert property (@(posedge clk_i) disable iff (!rstn)
      tx_valid_o |-> state_q == TX_HANDSHAKE);

endmodule

`default_nettype wire

// ==== rtl/sie_pkg.sv ====
// ************************************************************
// Design types of the serial interface engine.
// Field widths and the controller state encoding.
// ************************************************************
`default_nettype none

package sie_pkg;

   localparam int BYTE_W  = 8;
   localparam int ADDR_W  = 7;
   localparam int ENDP_W  = 4;
   localparam int FRAME_W = 11;

   typedef logic [BYTE_W-1:0]  byte_t;
   typedef logic [ADDR_W-1:0]  usb_addr_t;
   typedef logic [ENDP_W-1:0]  endp_t;
   typedef logic [FRAME_W-1:0] frame_t;

   // Packet sequencing states.
   typedef enum logic [3:0] {
      IDLE,
      RX_PID,
      RX_TOKEN,
      RX_DATA,
      RX_WAIT_EOP,
      TX_HANDSHAKE
   } ctrl_state_t;

endpackage

`default_nettype wire

// ==== rtl/sie_top.sv ====
// ************************************************************
// Top level of the byte-level USB device engine.
// Connects the packet controller, the token decoder
// and the OUT data receive path.
// ************************************************************
`default_nettype none

module sie_top
   import sie_pkg::*;
#(
   parameter endp_t ENDP_CTRL = 4'd0,
   parameter endp_t ENDP_BULK = 4'd1
) (
   input  wire            clk_i,
   input  wire            rstn,
   input  wire byte_t     rx_data_i,
   input  wire            rx_strobe_i,
   input  wire            rx_active_i,
   input  wire            rx_err_i,
   input  wire            tx_done_i,
   input  wire usb_addr_t addr_i,
   input  wire            stall_i,
   input  wire            out_nak_i,
   input  wire            out_toggle_reset_i,
   output logic           tx_valid_o,
   output byte_t          tx_data_o,
   output byte_t          out_data_o,
   output logic           out_valid_o,
   output logic           out_eop_o,
   output logic           out_err_o,
   output logic           setup_o,
   output endp_t          endp_o,
   output frame_t         frame_o
);

   // Controller to datapaths.
   logic  tok_byte_en;
   logic  tok_end;
   logic  tok_is_sof;
   logic  data_start;
   logic  data_byte_en;
   logic  data_end;

   // Datapaths back to the controller.
   logic  tok_ok;
   logic  addr_match;
   endp_t tok_endp;
   logic  crc_ok;

   sie_ctrl #(
      .ENDP_CTRL (ENDP_CTRL),
      .ENDP_BULK (ENDP_BULK)
   ) u_ctrl (
      .clk_i              (clk_i),
      .rstn               (rstn),
      .rx_data_i          (rx_data_i),
      .rx_strobe_i        (rx_strobe_i),
      .rx_active_i        (rx_active_i),
      .rx_err_i           (rx_err_i),
      .tx_done_i          (tx_done_i),
      .stall_i            (stall_i),
      .out_nak_i          (out_nak_i),
      .out_toggle_reset_i (out_toggle_reset_i),
      .tok_ok             (tok_ok),
      .addr_match         (addr_match),
      .tok_endp           (tok_endp),
      .crc_ok             (crc_ok),
      .tok_byte_en        (tok_byte_en),
      .tok_end            (tok_end),
      .tok_is_sof         (tok_is_sof),
      .data_start         (data_start),
      .data_byte_en       (data_byte_en),
      .data_end           (data_end),
      .tx_valid_o         (tx_valid_o),
      .tx_data_o          (tx_data_o),
      .out_eop_o          (out_eop_o),
      .out_err_o          (out_err_o),
      .setup_o            (setup_o)
   );

   token_decoder #(
      .ENDP_CTRL (ENDP_CTRL)
   ) u_token (
      .clk_i       (clk_i),
      .rstn        (rstn),
      .rx_data_i   (rx_data_i),
      .tok_byte_en (tok_byte_en),
      .tok_end     (tok_end),
      .is_sof_i    (tok_is_sof),
      .addr_i      (addr_i),
      .tok_ok      (tok_ok),
      .tok_addr    (),
      .tok_endp    (tok_endp),
      .addr_match  (addr_match),
      .endp_o      (endp_o),
      .frame_o     (frame_o)
   );

   data_rx_path u_data (
      .clk_i        (clk_i),
      .rstn         (rstn),
      .rx_data_i    (rx_data_i),
      .data_start   (data_start),
      .data_byte_en (data_byte_en),
      .data_end     (data_end),
      .out_data_o   (out_data_o),
      .out_valid_o  (out_valid_o),
      .crc_ok       (crc_ok)
   );

endmodule

`default_nettype wire

// ==== rtl/token_decoder.sv ====
// ************************************************************
// Token field decoder.
// Collects the two token bytes, checks CRC5 and holds
// the device address, endpoint and frame number.
// ************************************************************
`default_nettype none

module token_decoder
   import usb_proto_pkg::*;
   import sie_pkg::*;
#(
   parameter endp_t ENDP_CTRL = 4'd0
) (
   input  wire            clk_i,
   input  wire            rstn,
   input  wire byte_t     rx_data_i,
   input  wire            tok_byte_en,
   input  wire            tok_end,
   input  wire            is_sof_i,
   input  wire usb_addr_t addr_i,
   output logic           tok_ok,
   output usb_addr_t      tok_addr,
   output endp_t          tok_endp,
   output logic           addr_match,
   output endp_t          endp_o,
   output frame_t         frame_o
);

   byte_t  lo_q;
   logic   lo_valid_q;
   frame_t field;
   logic   crc_match;

   // 11-bit field spans the first byte and the low bits of the second.
   assign field     = {rx_data_i[2:0], lo_q};
   assign crc_match = (crc5_calc(field) == rev5(~rx_data_i[7:3]));

   assign addr_match = (tok_addr == addr_i);
   assign endp_o     = tok_endp;

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         lo_valid_q <= 1'b0;
         tok_ok     <= 1'b0;
         tok_addr   <= '0;
         tok_endp   <= ENDP_CTRL;
         frame_o    <= '0;
      end else begin
         tok_ok <= tok_end && lo_valid_q && crc_match;
         if (tok_end)
            lo_valid_q <= 1'b0;
         else if (tok_byte_en)
            lo_valid_q <= 1'b1;
         if (tok_end && lo_valid_q && crc_match) begin
            if (is_sof_i) begin
               frame_o <= field;
            end else begin
               tok_addr <= field[6:0];
               tok_endp <= field[10:7];
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (tok_byte_en && !tok_end) begin
         lo_q <= rx_data_i;
      end
   end

   a_end_after_byte: assert property (@(posedge clk_i) disable iff (!rstn)
      tok_end |-> tok_byte_en && lo_valid_q);

endmodule

`default_nettype wire

// ==== rtl/usb_proto_pkg.sv ====
// ************************************************************
// USB protocol definitions for the device-side engine.
// PID codes, CRC polynomials and the CRC16 residual.
// CRC5 and CRC16 helper functions, LSB first.
// ************************************************************
`default_nettype none

package usb_proto_pkg;

   typedef logic [3:0] pid_t;

   // Token PIDs.
   localparam pid_t PID_OUT      = 4'b0001;
   localparam pid_t PID_IN       = 4'b1001;
   localparam pid_t PID_SOF      = 4'b0101;
   localparam pid_t PID_SETUP    = 4'b1101;
   // Data PIDs, bit 3 carries the toggle.
   localparam pid_t PID_DATA0    = 4'b0011;
   localparam pid_t PID_DATA1    = 4'b1011;
   // Handshake PIDs.
   localparam pid_t PID_ACK      = 4'b0010;
   localparam pid_t PID_NAK      = 4'b1010;
   localparam pid_t PID_STALL    = 4'b1110;
   localparam pid_t PID_RESERVED = 4'b0000;

   localparam logic [4:0]  CRC5_POLY      = 5'b00101;
   localparam logic [15:0] CRC16_POLY     = 16'h8005;
   // Remainder left after the CRC bytes have been folded in.
   localparam logic [15:0] CRC16_RESIDUAL = 16'h800D;

   function automatic logic [4:0] crc5_calc(input logic [10:0] data);
      logic [4:0] crc;
      crc = 5'b11111;
      for (int i = 0; i < 11; i++) begin
         if (data[i] ^ crc[4])
            crc = {crc[3:0], 1'b0} ^ CRC5_POLY;
         else
            crc = {crc[3:0], 1'b0};
      end
      return crc;
   endfunction

   function automatic logic [15:0] crc16_step(input logic [7:0] data,
                                              input logic [15:0] crc_in);
      logic [15:0] crc;
      crc = crc_in;
      for (int i = 0; i < 8; i++) begin
         if (data[i] ^ crc[15])
            crc = {crc[14:0], 1'b0} ^ CRC16_POLY;
         else
            crc = {crc[14:0], 1'b0};
      end
      return crc;
   endfunction

   function automatic logic [4:0] rev5(input logic [4:0] data);
      logic [4:0] r;
      for (int i = 0; i < 5; i++) begin
         r[i] = data[4-i];
      end
      return r;
   endfunction

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the engine testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_sie \
   -Mdir obj_dir > compile.log 2>&1
if [ $? -ne 0 ]; then
   cat compile.log
   echo "Compilation with Verilator did not succeed"
   exit 1
fi

./obj_dir/Vtb_sie > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "Test passed" sim.log; then
   exit 0
fi
exit 1

// ==== testbench/tb_packets.svh ====
// ************************************************************
// Packet helpers for the engine testbench.
// LFSR, reference CRC5/CRC16 and byte-driving tasks.
// ************************************************************
`ifndef TB_PACKETS_SVH
`define TB_PACKETS_SVH

// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1.
logic [15:0] lfsr_q = 16'd15;

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
   return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// One LFSR step per payload bit.
task automatic rand_byte(output byte_t b);
   for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      b[i] = lfsr_q[0];
   end
endtask

function automatic byte_t pid_byte(input logic [3:0] p);
   return {~p, p};
endfunction

// CRC5 over the 11-bit token field, LSB first, preset to ones.
function automatic logic [4:0] ref_crc5(input logic [10:0] field);
   logic [4:0] c;
   logic       fb;
   c = 5'h1F;
   for (int i = 0; i < 11; i++) begin
      fb = field[i] ^ c[4];
      c = {c[3:0], 1'b0};
      if (fb)
         c = c ^ 5'h05;
   end
   return c;
endfunction

// Both token bytes, the inverted CRC5 sent from its top bit down.
function automatic logic [15:0] token_bytes(input logic [10:0] field);
   logic [4:0]  c;
   logic [15:0] t;
   c = ref_crc5(field);
   t = {5'b0, field};
   for (int i = 0; i < 5; i++) begin
      t[11+i] = ~c[4-i];
   end
   return t;
endfunction

function automatic logic [15:0] ref_crc16(input byte_t data[$]);
   logic [15:0] c;
   logic        fb;
   c = 16'hFFFF;
   foreach (data[k]) begin
      for (int i = 0; i < 8; i++) begin
         fb = data[k][i] ^ c[15];
         c = {c[14:0], 1'b0};
         if (fb)
            c = c ^ 16'h8005;
      end
   end
   return c;
endfunction

// One strobed byte, then a few idle cycles.
task automatic send_byte(input byte_t b, input logic more);
   @(posedge clk_i);
   #2;
   rx_data_i   = b;
   rx_active_i = more;
   rx_strobe_i = 1'b1;
   @(posedge clk_i);
   #2;
   rx_strobe_i = 1'b0;
   repeat (GAP) @(posedge clk_i);
endtask

task automatic send_token(input logic [3:0] pid, input logic [10:0] field,
                          input logic bad_crc);
   logic [15:0] t;
   t = token_bytes(field);
   if (bad_crc)
      t[15] = ~t[15];
   send_byte(pid_byte(pid), 1'b1);
   send_byte(t[7:0], 1'b1);
   send_byte(t[15:8], 1'b0);
endtask

// Random payload; bytes meant for the device are queued for the compare.
task automatic send_data(input logic [3:0] pid, input int n, input logic to_dev,
                         input logic bad_crc);
   byte_t       pay[$];
   byte_t       b;
   byte_t       c0;
   byte_t       c1;
   logic [15:0] c;
   for (int i = 0; i < n; i++) begin
      rand_byte(b);
      pay.push_back(b);
      if (to_dev)
         exp_q.push_back(b);
   end
   c = ref_crc16(pay);
   for (int j = 0; j < 8; j++) begin
      c0[j] = ~c[15-j];
      c1[j] = ~c[7-j];
   end
   if (bad_crc)
      c1 = c1 ^ 8'h01;
   send_byte(pid_byte(pid), 1'b1);
   foreach (pay[i]) begin
      send_byte(pay[i], 1'b1);
   end
   send_byte(c0, 1'b1);
   send_byte(c1, 1'b0);
endtask

`endif

// ==== testbench/tb_sie.sv ====
// ************************************************************
// Testbench for the byte-level USB device engine.
// Clock, reset, test sequence, payload compare and counts.
// ************************************************************
`default_nettype none

module tb_sie
   import sie_pkg::*;
();

   localparam usb_addr_t DEV_ADDR = 7'h2A;
   localparam endp_t     EP_CTRL  = 4'd0;
   localparam endp_t     EP_BULK  = 4'd1;
   localparam int GAP       = 3;
   localparam int NUM_PKTS  = 18;
   localparam int MAX_BYTES = 11;
   // Each byte takes a strobe cycle, one edge to drop it and the gap.
   localparam int CYCLE_LIMIT = NUM_PKTS * MAX_BYTES * (GAP + 2) * 2 + 200;

   localparam logic [3:0] P_OUT   = 4'h1;
   localparam logic [3:0] P_SOF   = 4'h5;
   localparam logic [3:0] P_SETUP = 4'hD;
   localparam logic [3:0] P_DATA0 = 4'h3;
   localparam logic [3:0] P_DATA1 = 4'hB;
   localparam logic [3:0] P_ACK   = 4'h2;
   localparam logic [3:0] P_NAK   = 4'hA;
   localparam logic [3:0] P_STALL = 4'hE;

   logic      clk_i;
   logic      rstn;
   byte_t     rx_data_i;
   logic      rx_strobe_i;
   logic      rx_active_i;
   logic      rx_err_i;
   logic      tx_done_i = 1'b0;
   usb_addr_t addr_i;
   logic      stall_i;
   logic      out_nak_i;
   logic      out_toggle_reset_i;
   logic      tx_valid_o;
   byte_t     tx_data_o;
   byte_t     out_data_o;
   logic      out_valid_o;
   logic      out_eop_o;
   logic      out_err_o;
   logic      setup_o;
   endp_t     endp_o;
   frame_t    frame_o;

   byte_t      exp_q[$];
   byte_t      hs_q[$];
   logic [1:0] tog_ref;
   int         seq_errors = 0;
   int         mon_errors = 0;
   int         eop_cnt = 0;
   int         err_cnt = 0;
   int         cycles = 0;

   `include "tb_packets.svh"

   sie_top #(
      .ENDP_CTRL (EP_CTRL),
      .ENDP_BULK (EP_BULK)
   ) u_dut (
      .clk_i              (clk_i),
      .rstn               (rstn),
      .rx_data_i          (rx_data_i),
      .rx_strobe_i        (rx_strobe_i),
      .rx_active_i        (rx_active_i),
      .rx_err_i           (rx_err_i),
      .tx_done_i          (tx_done_i),
      .addr_i             (addr_i),
      .stall_i            (stall_i),
      .out_nak_i          (out_nak_i),
      .out_toggle_reset_i (out_toggle_reset_i),
      .tx_valid_o         (tx_valid_o),
      .tx_data_o          (tx_data_o),
      .out_data_o         (out_data_o),
      .out_valid_o        (out_valid_o),
      .out_eop_o          (out_eop_o),
      .out_err_o          (out_err_o),
      .setup_o            (setup_o),
      .endp_o             (endp_o),
      .frame_o            (frame_o)
   );

   initial clk_i = 1'b0;
   always #10 clk_i = ~clk_i;

   task automatic check(input logic [31:0] got, input logic [31:0] exp,
                        input string what, inout int errs);
      if (got !== exp) begin
         $display("Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
         errs++;
      end
   endtask

   // Expected handshake byte. Stall wins over NAK.
   function automatic byte_t expect_hs(input logic stall, input logic nak);
      logic [3:0] p;
      p = stall ? P_STALL : (nak ? P_NAK : P_ACK);
      return {~p, p};
   endfunction

   task automatic report(input int num, input string name, input int base);
      $display("Test %0d (%s) finished with %0d mismatches", num, name,
               seq_errors + mon_errors - base);
   endtask

   // Token and data stage to this device against the toggle model.
   task automatic out_transfer(input logic is_setup, input endp_t ep, input logic data1,
                               input logic stall, input logic nak);
      int   idx;
      int   eop0;
      int   err0;
      logic accept;
      idx = (ep == EP_BULK) ? 1 : 0;
      eop0 = eop_cnt;
      err0 = err_cnt;
      @(posedge clk_i);
      #2;
      stall_i = stall;
      out_nak_i = nak;
      send_token(is_setup ? P_SETUP : P_OUT, {ep, DEV_ADDR}, 1'b0);
      check(32'(setup_o), 32'(is_setup), "setup level", seq_errors);
      check(32'(endp_o), 32'(ep), "endpoint", seq_errors);
      if (is_setup)
         tog_ref[0] = 1'b0;
      accept = (tog_ref[idx] == data1);
      if (accept && (stall || !nak))
         tog_ref[idx] = ~tog_ref[idx];
      send_data(data1 ? P_DATA1 : P_DATA0, 8, 1'b1, 1'b0);
      while (hs_q.size() == 0) @(negedge clk_i);
      check(32'(hs_q.pop_front()), 32'(expect_hs(stall, nak)), "handshake", seq_errors);
      check(eop_cnt - eop0, 32'(accept), "eop pulses", seq_errors);
      check(err_cnt - err0, 32'(!accept), "error pulses", seq_errors);
      check(exp_q.size(), 0, "payload bytes missing", seq_errors);
      @(posedge clk_i);
      #2;
      stall_i = 1'b0;
      out_nak_i = 1'b0;
   endtask

   // Handshake transmitter takes each byte one cycle after it appears.
   always @(posedge clk_i) begin
      #2;
      tx_done_i = tx_valid_o && !tx_done_i;
   end

   // Payload compare and pulse counting.
   always @(negedge clk_i) begin
      if (rstn) begin
         if (out_valid_o) begin
            if (exp_q.size() == 0) begin
               $display("Unexpected payload byte %0h on the output at time %0t",
                        out_data_o, $time);
               mon_errors++;
            end else begin
               check(32'(out_data_o), 32'(exp_q.pop_front()), "payload byte", mon_errors);
            end
         end
         if (out_eop_o)
            eop_cnt++;
         if (out_err_o)
            err_cnt++;
         if (tx_valid_o && tx_done_i)
            hs_q.push_back(tx_data_o);
      end
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      int base;
      int err0;
      int eop0;
      rstn = 1'b0;
      rx_data_i = '0;
      rx_strobe_i = 1'b0;
      rx_active_i = 1'b0;
      rx_err_i = 1'b0;
      addr_i = DEV_ADDR;
      stall_i = 1'b0;
      out_nak_i = 1'b0;
      out_toggle_reset_i = 1'b0;
      tog_ref = 2'b00;
      repeat (8) @(posedge clk_i);
      #2;
      rstn = 1'b1;

      base = seq_errors + mon_errors;
      send_token(P_SOF, 11'h5A3, 1'b0);
      check(32'(frame_o), 32'h5A3, "frame after SOF", seq_errors);
      send_token(P_SOF, 11'h123, 1'b1);
      check(32'(frame_o), 32'h5A3, "frame after bad SOF", seq_errors);
      report(1, "SOF frame capture", base);

      base = seq_errors + mon_errors;
      out_transfer(1'b1, EP_CTRL, 1'b0, 1'b0, 1'b0);
      report(2, "SETUP with DATA0", base);

      base = seq_errors + mon_errors;
      out_transfer(1'b0, EP_BULK, 1'b0, 1'b0, 1'b0);
      out_transfer(1'b0, EP_BULK, 1'b0, 1'b0, 1'b0);
      report(3, "bulk toggle repeat", base);

      // A bad CRC16 still lets the bytes out but stops the handshake.
      base = seq_errors + mon_errors;
      err0 = err_cnt;
      send_token(P_OUT, {EP_BULK, DEV_ADDR}, 1'b0);
      send_data(P_DATA1, 8, 1'b1, 1'b1);
      while (err_cnt == err0) @(negedge clk_i);
      repeat (4) @(negedge clk_i);
      check(hs_q.size(), 0, "handshakes after bad CRC", seq_errors);
      check(exp_q.size(), 0, "payload bytes missing", seq_errors);
      report(4, "bad CRC16", base);

      base = seq_errors + mon_errors;
      out_transfer(1'b0, EP_BULK, 1'b1, 1'b1, 1'b0);
      out_transfer(1'b0, EP_BULK, 1'b0, 1'b0, 1'b1);
      out_transfer(1'b0, EP_BULK, 1'b0, 1'b0, 1'b0);
      report(5, "STALL and NAK", base);

      base = seq_errors + mon_errors;
      err0 = err_cnt;
      eop0 = eop_cnt;
      send_token(P_OUT, {EP_BULK, DEV_ADDR ^ 7'h01}, 1'b0);
      send_data(P_DATA0, 8, 1'b0, 1'b0);
      repeat (10) @(negedge clk_i);
      check(eop_cnt - eop0, 0, "eop pulses", seq_errors);
      check(err_cnt - err0, 0, "error pulses", seq_errors);
      check(hs_q.size(), 0, "handshakes to other address", seq_errors);
      report(6, "other address", base);

      $display("Tests run: 6, mismatches: %0d", seq_errors + mon_errors);
      if (seq_errors + mon_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
